// File: wb_bus_pkg.sv
// wishbone bus types
package wb_bus_pkg;

    localparam int WB_ADDR_W = 32;
    localparam int WB_DATA_W = 32;
    localparam int WB_SEL_W  = 2;   // two halfword lanes

    // cpu side command, wr on top as in the cpu word
    typedef struct packed {
        logic                 wr;
        logic                 rd;
        logic [WB_DATA_W-1:0] wdata;
    } cpu_cmd_t;

    // classic cycle request from the master
    typedef struct packed {
        logic [WB_ADDR_W-1:0] addr;
        logic [WB_DATA_W-1:0] wdata;
        logic                 we;
        logic                 cyc;
        logic                 stb;
        logic [WB_SEL_W-1:0]  sel;   // bit 0 low halfword, bit 1 high halfword
    } wb_req_t;

    // slave answer
    typedef struct packed {
        logic [WB_DATA_W-1:0] rdata;
        logic                 ack;
    } wb_rsp_t;

    // master FSM
    typedef enum logic [1:0] {
        WB_IDLE,
        WB_STROBE,     // cyc and stb out
        WB_WAIT_ACK    // stb dropped, cyc held
    } wb_state_e;

endpackage

// File: soc_map_pkg.sv
// address map and device registers
package soc_map_pkg;

    // bit 29 set means device space
    localparam int DEV_SPACE_BIT = 29;

    // lane enables live in address bits 17:16 for devices
    localparam int DEV_SEL_LSB = 16;

    // data ram, word indexed from address bits 9:2
    localparam int RAM_WORDS    = 256;
    localparam int RAM_IDX_BITS = 8;

    // device register select, address bits 3:2
    typedef enum logic [1:0] {
        DEV_SCRATCH = 2'd0,
        DEV_ACCUM   = 2'd1,
        DEV_ID      = 2'd2,
        DEV_WCOUNT  = 2'd3
    } dev_reg_e;

    localparam logic [31:0] DEV_ID_VALUE = 32'h57B0_0001;

endpackage

// File: wb_master.sv
// wishbone master
`timescale 1ns/1ps

module wb_master (
    input  logic                                clk_i,
    input  logic                                rst_i,

    // cpu side
    input  logic [wb_bus_pkg::WB_ADDR_W-1:0]    cmd_addr_i,
    input  wb_bus_pkg::cpu_cmd_t                cmd_i,
    output logic                                cmd_busy_o,
    output logic [wb_bus_pkg::WB_DATA_W-1:0]    cmd_rdata_o,
    output logic                                cmd_rdata_valid_o,

    // bus side
    output wb_bus_pkg::wb_req_t                 wb_req_o,
    input  wb_bus_pkg::wb_rsp_t                 wb_rsp_i
);

    import wb_bus_pkg::*;
    import soc_map_pkg::*;

    wb_state_e           state_q;
    wb_req_t             req_q;
    logic                is_read_q;   // only reads raise valid
    logic                ack_seen;
    logic                accept;
    logic [WB_SEL_W-1:0] lane_sel;

    assign ack_seen = (state_q == WB_WAIT_ACK) && wb_rsp_i.ack;

    // a new command may start in the same edge that closes the old cycle
    assign accept = ((state_q == WB_IDLE) || ack_seen) && (cmd_i.rd || cmd_i.wr);

    assign cmd_busy_o = (state_q != WB_IDLE) && !ack_seen;

    // lane rule
    always_comb begin
        if (cmd_addr_i[DEV_SPACE_BIT]) begin
            lane_sel = cmd_addr_i[DEV_SEL_LSB +: WB_SEL_W];
        end else begin
            lane_sel = '1;   // ram uses both halves
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q.addr  <= cmd_addr_i;
            req_q.wdata <= cmd_i.wdata;
        end
        if (ack_seen) begin
            cmd_rdata_o <= wb_rsp_i.rdata;
        end

        if (!rst_i) begin
            state_q           <= WB_IDLE;
            req_q.we          <= 1'b0;
            req_q.cyc         <= 1'b0;
            req_q.stb         <= 1'b0;
            req_q.sel         <= '0;
            is_read_q         <= 1'b0;
            cmd_rdata_valid_o <= 1'b0;
        end else begin
            cmd_rdata_valid_o <= ack_seen && is_read_q;

            if (accept) begin
                state_q   <= WB_STROBE;
                req_q.cyc <= 1'b1;
                req_q.stb <= 1'b1;
                req_q.we  <= cmd_i.wr && !cmd_i.rd;   // rd wins
                req_q.sel <= lane_sel;
                is_read_q <= cmd_i.rd;
            end else if (state_q == WB_STROBE) begin
                state_q   <= WB_WAIT_ACK;
                req_q.stb <= 1'b0;   // single strobe per cycle
            end else if (ack_seen) begin
                state_q   <= WB_IDLE;
                req_q.cyc <= 1'b0;
                req_q.we  <= 1'b0;
                req_q.sel <= '1;
                is_read_q <= 1'b0;
            end else if (state_q == WB_IDLE) begin
                req_q.sel <= '1;   // idle lanes
            end
        end
    end

    assign wb_req_o = req_q;

    a_stb_in_cyc : assert property (
        @(posedge clk_i) disable iff (!rst_i)
        wb_req_o.stb |-> wb_req_o.cyc
    ) else $error("wb_master: stb high outside a cycle");

endmodule

// File: wb_data_ram.sv
// wishbone data ram
`timescale 1ns/1ps

module wb_data_ram (
    input  logic                clk_i,
    input  logic                rst_i,
    input  wb_bus_pkg::wb_req_t req_i,
    output wb_bus_pkg::wb_rsp_t rsp_o
);

    import wb_bus_pkg::*;
    import soc_map_pkg::*;

    logic [WB_DATA_W-1:0]    mem [RAM_WORDS];
    logic [RAM_IDX_BITS-1:0] idx;
    logic [WB_DATA_W-1:0]    rdata_q;
    logic                    ack_q;
    logic                    strobe;

    assign strobe = req_i.cyc && req_i.stb;
    assign idx    = req_i.addr[RAM_IDX_BITS+1:2];   // word address

    // whole words only, lanes are always both set here
    always_ff @(posedge clk_i) begin
        if (strobe) begin
            if (req_i.we) begin
                mem[idx] <= req_i.wdata;
            end else begin
                rdata_q <= mem[idx];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= strobe;   // one registered ack
        end
    end

    assign rsp_o = '{rdata: rdata_q, ack: ack_q};

    a_ack_single : assert property (
        @(posedge clk_i) disable iff (!rst_i)
        rsp_o.ack |=> !rsp_o.ack
    ) else $error("wb_data_ram: ack held for two cycles");

endmodule

// File: wb_dev_regs.sv
// device register block
`timescale 1ns/1ps

module wb_dev_regs (
    input  logic                clk_i,
    input  logic                rst_i,
    input  wb_bus_pkg::wb_req_t req_i,
    output wb_bus_pkg::wb_rsp_t rsp_o
);

    import wb_bus_pkg::*;
    import soc_map_pkg::*;

    logic [WB_DATA_W-1:0] scratch_q;
    logic [WB_DATA_W-1:0] accum_q;
    logic [WB_DATA_W-1:0] wcount_q;
    logic [WB_DATA_W-1:0] rdata_q;
    logic [WB_DATA_W-1:0] rd_mux;
    logic [WB_DATA_W-1:0] lane_mask;
    logic                 ack_q;
    logic                 strobe;
    dev_reg_e             reg_idx;

    assign strobe    = req_i.cyc && req_i.stb;
    assign reg_idx   = dev_reg_e'(req_i.addr[3:2]);
    assign lane_mask = {{16{req_i.sel[1]}}, {16{req_i.sel[0]}}};

    always_comb begin
        unique case (reg_idx)
            DEV_SCRATCH: rd_mux = scratch_q;
            DEV_ACCUM:   rd_mux = accum_q;
            DEV_ID:      rd_mux = DEV_ID_VALUE;
            DEV_WCOUNT:  rd_mux = wcount_q;
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            scratch_q <= '0;
            accum_q   <= '0;
            wcount_q  <= '0;
            rdata_q   <= '0;
            ack_q     <= 1'b0;
        end else begin
            ack_q <= strobe;
            if (strobe && req_i.we) begin
                wcount_q <= wcount_q + 1'b1;   // every device write counts
                case (reg_idx)
                    DEV_SCRATCH: scratch_q <= (scratch_q & ~lane_mask) |
                                              (req_i.wdata & lane_mask);
                    DEV_ACCUM:   accum_q <= accum_q + (req_i.wdata & lane_mask);
                    default: ;   // id and count are read only
                endcase
            end
            if (strobe && !req_i.we) begin
                rdata_q <= rd_mux;
            end
        end
    end

    assign rsp_o = '{rdata: rdata_q, ack: ack_q};

    // ack only answers a strobe decoded to device space
    a_ack_after_stb : assert property (
        @(posedge clk_i) disable iff (!rst_i)
        rsp_o.ack |-> $past(req_i.cyc && req_i.stb && req_i.addr[DEV_SPACE_BIT])
    ) else $error("wb_dev_regs: ack without a preceding device strobe");

endmodule

// File: wb_bus_mux.sv
// wishbone address decode and response merge
`timescale 1ns/1ps

module wb_bus_mux (
    input  logic                clk_i,
    input  logic                rst_i,

    input  wb_bus_pkg::wb_req_t req_i,
    output wb_bus_pkg::wb_req_t ram_req_o,
    output wb_bus_pkg::wb_req_t dev_req_o,

    input  wb_bus_pkg::wb_rsp_t ram_rsp_i,
    input  wb_bus_pkg::wb_rsp_t dev_rsp_i,
    output wb_bus_pkg::wb_rsp_t rsp_o
);

    import soc_map_pkg::*;

    logic dev_hit;

    assign dev_hit = req_i.addr[DEV_SPACE_BIT];

    // only the strobe is steered, the rest fans out
    always_comb begin
        ram_req_o     = req_i;
        ram_req_o.stb = req_i.stb && !dev_hit;
        dev_req_o     = req_i;
        dev_req_o.stb = req_i.stb && dev_hit;
    end

    always_comb begin
        rsp_o.ack   = ram_rsp_i.ack || dev_rsp_i.ack;
        rsp_o.rdata = dev_rsp_i.ack ? dev_rsp_i.rdata : ram_rsp_i.rdata;
    end

    a_one_ack : assert property (
        @(posedge clk_i) disable iff (!rst_i)
        !(ram_rsp_i.ack && dev_rsp_i.ack)
    ) else $error("wb_bus_mux: both slaves acked");

endmodule

// File: wb_subsys_top.sv
// cpu bus bridge top
`timescale 1ns/1ps

module wb_subsys_top (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic [wb_bus_pkg::WB_ADDR_W-1:0] cmd_addr_i,
    input  wb_bus_pkg::cpu_cmd_t             cmd_i,
    output logic                             cmd_busy_o,
    output logic [wb_bus_pkg::WB_DATA_W-1:0] cmd_rdata_o,
    output logic                             cmd_rdata_valid_o
);

    import wb_bus_pkg::*;

    wb_req_t m_req;
    wb_req_t ram_req;
    wb_req_t dev_req;
    wb_rsp_t m_rsp;
    wb_rsp_t ram_rsp;
    wb_rsp_t dev_rsp;

    wb_master u_master (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .cmd_addr_i        (cmd_addr_i),
        .cmd_i             (cmd_i),
        .cmd_busy_o        (cmd_busy_o),
        .cmd_rdata_o       (cmd_rdata_o),
        .cmd_rdata_valid_o (cmd_rdata_valid_o),
        .wb_req_o          (m_req),
        .wb_rsp_i          (m_rsp)
    );

    wb_bus_mux u_mux (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .req_i     (m_req),
        .ram_req_o (ram_req),
        .dev_req_o (dev_req),
        .ram_rsp_i (ram_rsp),
        .dev_rsp_i (dev_rsp),
        .rsp_o     (m_rsp)
    );

    wb_data_ram u_ram (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (ram_req),
        .rsp_o (ram_rsp)
    );

    wb_dev_regs u_dev (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (dev_req),
        .rsp_o (dev_rsp)
    );

endmodule

// File: tb_ref_model.svh
// bridge reference model
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [31:0] model_ram [256];
logic [31:0] model_scratch;
logic [31:0] model_accum;
logic [31:0] model_wcount;

function automatic void model_reset();
    model_scratch = '0;
    model_accum   = '0;
    model_wcount  = '0;
endfunction

// ram fill pattern, every address bit counts
function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]} ^ 32'hC3A5_5A3C;
endfunction

function automatic logic [31:0] model_read(input logic [31:0] addr);
    if (!addr[DEV_SPACE_BIT]) begin
        return model_ram[addr[9:2]];
    end
    case (dev_reg_e'(addr[3:2]))
        DEV_SCRATCH: return model_scratch;
        DEV_ACCUM:   return model_accum;
        DEV_ID:      return DEV_ID_VALUE;
        default:     return model_wcount;
    endcase
endfunction

function automatic void model_write(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] mask;
    mask = {{16{addr[DEV_SEL_LSB + 1]}}, {16{addr[DEV_SEL_LSB]}}};   // device lanes
    if (!addr[DEV_SPACE_BIT]) begin
        model_ram[addr[9:2]] = wdata;   // ram takes whole words
        return;
    end
    model_wcount = model_wcount + 32'd1;
    case (dev_reg_e'(addr[3:2]))
        DEV_SCRATCH: model_scratch = (model_scratch & ~mask) | (wdata & mask);
        DEV_ACCUM:   model_accum = model_accum + (wdata & mask);
        default: ;   // id and count ignore the data
    endcase
endfunction

`endif

// File: tb_wb_subsys.sv
// bridge testbench
`timescale 1ns/1ps

module tb_wb_subsys;

    import wb_bus_pkg::*;
    import soc_map_pkg::*;

    localparam int          MAX_WAIT = 20;   // cycles per wait loop
    localparam logic [31:0] SEED     = 32'hb5c4;

    logic        clk_i;
    logic        rst_i;
    logic [31:0] cmd_addr_i;
    cpu_cmd_t    cmd_i;
    logic        cmd_busy_o;
    logic [31:0] cmd_rdata_o;
    logic        cmd_rdata_valid_o;

    int value_errs;
    int other_errs;
    int n_cmds;
    bit aborted;

    `include "tb_ref_model.svh"

    wb_subsys_top u_dut (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .cmd_addr_i        (cmd_addr_i),
        .cmd_i             (cmd_i),
        .cmd_busy_o        (cmd_busy_o),
        .cmd_rdata_o       (cmd_rdata_o),
        .cmd_rdata_valid_o (cmd_rdata_valid_o)
    );

    always #10 clk_i = ~clk_i;

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            value_errs++;
            $display("ERR %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic report_fault(input string what);
        other_errs++;
        $display("%s (t=%0t)", what, $time);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk_i);
        while (cmd_busy_o && n < MAX_WAIT) begin
            @(negedge clk_i);
            n++;
        end
        if (cmd_busy_o) begin
            report_fault("busy never fell before a new command");
            aborted = 1'b1;
        end
    endtask

    // one command, held through the first busy edge
    task automatic run_cmd(input string name, input logic [31:0] addr,
                           input logic rd, input logic wr, input logic [31:0] wdata);
        cpu_cmd_t    c;
        logic [31:0] exp_data;
        int          lat;
        bit          done;
        if (aborted) return;
        exp_data = model_read(addr);
        wait_idle();
        if (aborted) return;
        c.rd    = rd;
        c.wr    = wr;
        c.wdata = wdata;
        @(posedge clk_i);
        cmd_addr_i <= addr;
        cmd_i      <= c;
        @(posedge clk_i);   // accepted here
        n_cmds++;
        if (wr && !rd) begin
            model_write(addr, wdata);
        end
        @(negedge clk_i);
        if (!cmd_busy_o) begin
            report_fault({name, ": busy did not rise after an accepted command"});
        end
        @(posedge clk_i);
        cmd_i <= '0;
        lat  = 0;
        done = 1'b0;
        while (!done && lat < MAX_WAIT) begin
            @(negedge clk_i);
            lat++;
            if (cmd_rdata_valid_o && !rd) begin
                report_fault({name, ": read data valid pulsed after a write"});
            end
            done = rd ? cmd_rdata_valid_o : (!cmd_busy_o && lat >= 3);
        end
        if (!done) begin
            report_fault({name, ": timeout waiting for the command to finish"});
            aborted = 1'b1;
            return;
        end
        if (rd) begin
            check_eq({name, " latency"}, 32'd2, lat);
            check_eq(name, exp_data, cmd_rdata_o);
            if (cmd_busy_o) begin
                report_fault({name, ": busy still high with the read data"});
            end
            @(negedge clk_i);
            if (cmd_rdata_valid_o) begin
                report_fault({name, ": read data valid longer than one cycle"});
            end
        end
    endtask

    // mostly plain reads or writes, both flags now and then
    task automatic random_op(input string name, input logic [31:0] addr);
        logic rd;
        logic wr;
        rd = 1'($urandom_range(0, 1));
        wr = rd ? ($urandom_range(0, 3) == 0) : 1'b1;
        run_cmd(name, addr, rd, wr, $urandom());
    endtask

    function automatic logic [31:0] ram_addr();
        logic [31:0] a;
        a = $urandom();
        a[DEV_SPACE_BIT] = 1'b0;
        return a;
    endfunction

    function automatic logic [31:0] dev_addr(input dev_reg_e r);
        logic [31:0] a;
        a = $urandom();   // random lanes in 17:16
        a[DEV_SPACE_BIT] = 1'b1;
        a[3:2] = r;
        return a;
    endfunction

    function automatic dev_reg_e any_reg();
        return dev_reg_e'(2'($urandom_range(0, 3)));
    endfunction

    initial begin
        logic [31:0] a;
        clk_i      = 1'b0;
        rst_i      = 1'b0;
        cmd_addr_i = '0;
        cmd_i      = '0;
        value_errs = 0;
        other_errs = 0;
        n_cmds     = 0;
        aborted    = 1'b0;
        void'($urandom(SEED));
        model_reset();
        repeat (3) @(posedge clk_i);
        rst_i <= 1'b1;
        @(negedge clk_i);
        check_eq("reset_busy", 32'd0, cmd_busy_o);
        check_eq("reset_valid", 32'd0, cmd_rdata_valid_o);

        run_cmd("reset_scratch", dev_addr(DEV_SCRATCH), 1'b1, 1'b0, '0);
        run_cmd("reset_accum", dev_addr(DEV_ACCUM), 1'b1, 1'b0, '0);

        for (int i = 0; i < RAM_WORDS; i++) begin
            a = 32'(i) << 2;
            run_cmd("ram_fill", a, 1'b0, 1'b1, fill_word(a));
        end
        for (int i = 0; i < 200; i++) begin
            random_op("ram_rw", ram_addr());
        end
        for (int i = 0; i < 80; i++) begin
            random_op("dev_scratch", dev_addr(DEV_SCRATCH));
        end
        for (int i = 0; i < 80; i++) begin
            random_op("dev_accum", dev_addr(DEV_ACCUM));
        end
        for (int i = 0; i < 50; i++) begin
            run_cmd("dev_write", dev_addr(any_reg()), 1'b0, 1'b1, $urandom());
            run_cmd("dev_id", dev_addr(DEV_ID), 1'b1, 1'b0, '0);
            run_cmd("dev_wcount", dev_addr(DEV_WCOUNT), 1'b1, 1'b0, '0);
        end
        for (int i = 0; i < 150; i++) begin
            a = $urandom_range(0, 1) ? ram_addr() : dev_addr(any_reg());
            random_op("mixed", a);
        end

        $display("commands=%0d value_errors=%0d other_errors=%0d",
                 n_cmds, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+.
wb_bus_pkg.sv
soc_map_pkg.sv
wb_master.sv
wb_data_ram.sv
wb_dev_regs.sv
wb_bus_mux.sv
wb_subsys_top.sv
tb_wb_subsys.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_wb_subsys
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TB PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
